/* mem_defs.svh */
//****************************************
// byte addresses; SRAM aliases below IO_BASE
// I/O offsets are byte offsets in the window
//****************************************
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

`define DATA_W    32
`define SRAM_AW   20
`define BTN_W     4

// first fetch after reset
`define RESET_PC  32'h0000_0000

// I/O window and register offsets
`define IO_BASE   32'h1000_0000
`define LED_ADDR  32'h0000_0000
`define DPY_ADDR  32'h0000_0004
`define BTN_ADDR  32'h0000_0008

`endif

/* mem_pkg.sv */
//****************************************
// shared types of the memory subsystem
// byte enables are active low
//****************************************
`default_nettype none

package mem_pkg;

`include "mem_defs.svh"

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_t;

    typedef logic [`DATA_W-1:0]  word_t;
    typedef logic [`SRAM_AW-1:0] sram_addr_t;
    typedef logic [3:0]          be_t;

endpackage

`default_nettype wire

/* mem_bus_if.sv */
//****************************************
// req held with payload until ack, dropped after
// rdata valid only in the ack cycle
//****************************************
`default_nettype none

`include "mem_defs.svh"

interface mem_bus_if;
    logic                req;
    logic                we;
    logic [`SRAM_AW-1:0] addr;
    logic [3:0]          be_n;
    logic [`DATA_W-1:0]  wdata;
    logic [`DATA_W-1:0]  rdata;
    logic                ack;

    modport requester (
        output req, we, addr, be_n, wdata,
        input  rdata, ack
    );

    modport responder (
        input  req, we, addr, be_n, wdata,
        output rdata, ack
    );
endinterface

`default_nettype wire

/* fetch_unit.sv */
//****************************************
// one fetch in flight; redirect_pc_i must be
// word aligned
//****************************************
`default_nettype none

`include "mem_defs.svh"

module fetch_unit import mem_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_en_i,
    input  logic                redirect_i,
    input  word_t               redirect_pc_i,
    mem_bus_if.requester        bus,
    output logic                inst_valid_o,
    output word_t               inst_pc_o,
    output word_t               inst_o
);
    word_t pc;
    word_t pending_pc;
    logic  req_q;
    logic  stale;

    assign bus.req   = req_q;
    assign bus.we    = 1'b0;
    assign bus.be_n  = 4'b0000;
    assign bus.wdata = '0;
    assign bus.addr  = pc[`SRAM_AW+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= `RESET_PC;
            req_q        <= 1'b0;
            stale        <= 1'b0;
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= 1'b0;
            if (req_q) begin
                if (bus.ack) begin
                    req_q <= 1'b0;
                    if (stale || redirect_i) begin
                        // result belongs to the old stream
                        stale <= 1'b0;
                        pc    <= redirect_i ? redirect_pc_i : pending_pc;
                    end else begin
                        inst_valid_o <= 1'b1;
                        pc           <= pc + 32'd4;
                    end
                end else if (redirect_i) begin
                    stale <= 1'b1;
                end
            end else if (redirect_i) begin
                pc <= redirect_pc_i;
            end else if (fetch_en_i) begin
                req_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_q && !bus.ack && redirect_i) begin
            pending_pc <= redirect_pc_i;
        end
        if (req_q && bus.ack) begin
            inst_pc_o <= pc;
            inst_o    <= bus.rdata;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* load_store_unit.sv */
//****************************************
// little-endian lanes; op and address held
// until done; misaligned ops never issue
//****************************************
`default_nettype none

`include "mem_defs.svh"

module load_store_unit import mem_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                data_req_i,
    input  mem_op_t             data_op_i,
    input  word_t               data_addr_i,
    input  word_t               data_wdata_i,
    mem_bus_if.requester        mem_bus,
    mem_bus_if.requester        io_bus,
    output logic                data_done_o,
    output logic                data_err_o,
    output word_t               data_rdata_o
);
    logic  mem_req_q;
    logic  io_req_q;
    logic  io_sel;
    logic  is_store;
    logic  misaligned;
    logic  start;
    logic  bus_ack;
    be_t   be_n;
    word_t store_data;
    word_t io_offset;
    word_t rdata;
    word_t shifted;
    word_t load_val;

    assign io_sel    = data_addr_i >= `IO_BASE;
    assign io_offset = data_addr_i - `IO_BASE;
    assign is_store  = data_op_i inside {MEM_SB, MEM_SH, MEM_SW};
    assign start     = data_req_i && !data_done_o && !mem_req_q && !io_req_q;
    assign bus_ack   = (mem_req_q && mem_bus.ack) || (io_req_q && io_bus.ack);

    always_comb begin
        misaligned = 1'b0;
        be_n       = 4'b0000;
        store_data = data_wdata_i;
        case (data_op_i)
            MEM_LB, MEM_LBU, MEM_SB: begin
                be_n       = ~(4'b0001 << data_addr_i[1:0]);
                store_data = {4{data_wdata_i[7:0]}};
            end
            MEM_LH, MEM_LHU, MEM_SH: begin
                misaligned = data_addr_i[0];
                be_n       = ~(4'b0011 << {data_addr_i[1], 1'b0});
                store_data = {2{data_wdata_i[15:0]}};
            end
            MEM_LW, MEM_SW: misaligned = data_addr_i[1:0] != 2'b00;
            default: be_n = 4'b1111;
        endcase
    end

    assign mem_bus.req   = mem_req_q;
    assign mem_bus.we    = is_store;
    assign mem_bus.addr  = data_addr_i[`SRAM_AW+1:2];
    assign mem_bus.be_n  = be_n;
    assign mem_bus.wdata = store_data;

    assign io_bus.req    = io_req_q;
    assign io_bus.we     = is_store;
    assign io_bus.addr   = io_offset[`SRAM_AW+1:2];
    assign io_bus.be_n   = be_n;
    assign io_bus.wdata  = store_data;

    // addressed lane moved down to bit 0
    assign rdata   = io_req_q ? io_bus.rdata : mem_bus.rdata;
    assign shifted = rdata >> {data_addr_i[1:0], 3'b000};

    always_comb begin
        case (data_op_i)
            MEM_LB:  load_val = {{24{shifted[7]}}, shifted[7:0]};
            MEM_LBU: load_val = {24'b0, shifted[7:0]};
            MEM_LH:  load_val = {{16{shifted[15]}}, shifted[15:0]};
            MEM_LHU: load_val = {16'b0, shifted[15:0]};
            MEM_LW:  load_val = rdata;
            default: load_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_req_q   <= 1'b0;
            io_req_q    <= 1'b0;
            data_done_o <= 1'b0;
            data_err_o  <= 1'b0;
        end else begin
            data_done_o <= 1'b0;
            data_err_o  <= 1'b0;
            if (bus_ack) begin
                mem_req_q   <= 1'b0;
                io_req_q    <= 1'b0;
                data_done_o <= 1'b1;
            end else if (start) begin
                if (misaligned || data_op_i == MEM_NONE) begin
                    data_done_o <= 1'b1;
                    data_err_o  <= misaligned;
                end else begin
                    mem_req_q <= !io_sel;
                    io_req_q  <= io_sel;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_ack) begin
            data_rdata_o <= load_val;
        end else if (start && (misaligned || data_op_i == MEM_NONE)) begin
            data_rdata_o <= '0;
        end
    end

    // replies only come back on the bus that is waiting
    a_ack_owned: assert property (@(posedge clk) disable iff (rst)
        !(mem_bus.ack && !mem_req_q) && !(io_bus.ack && !io_req_q));

endmodule

`default_nettype wire

/* bus_arbiter.sv */
//****************************************
// data beats fetch on a tie; no owner means
// the SRAM controller is idle
//****************************************
`default_nettype none

module bus_arbiter import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    mem_bus_if.responder    fetch_bus,
    mem_bus_if.responder    data_bus,
    mem_bus_if.requester    sram_bus
);
    typedef enum logic [1:0] {OWN_NONE, OWN_FETCH, OWN_DATA} owner_t;

    owner_t owner;
    owner_t sel;

    // a new grant passes through in the same cycle
    always_comb begin
        sel = owner;
        if (owner == OWN_NONE) begin
            if (data_bus.req) begin
                sel = OWN_DATA;
            end else if (fetch_bus.req) begin
                sel = OWN_FETCH;
            end
        end
    end

    always_comb begin
        sram_bus.req   = 1'b0;
        sram_bus.we    = 1'b0;
        sram_bus.addr  = fetch_bus.addr;
        sram_bus.be_n  = 4'b1111;
        sram_bus.wdata = '0;
        if (sel == OWN_DATA) begin
            sram_bus.req   = data_bus.req;
            sram_bus.we    = data_bus.we;
            sram_bus.addr  = data_bus.addr;
            sram_bus.be_n  = data_bus.be_n;
            sram_bus.wdata = data_bus.wdata;
        end else if (sel == OWN_FETCH) begin
            sram_bus.req   = fetch_bus.req;
            sram_bus.we    = fetch_bus.we;
            sram_bus.be_n  = fetch_bus.be_n;
            sram_bus.wdata = fetch_bus.wdata;
        end
    end

    assign data_bus.ack    = sram_bus.ack && (owner == OWN_DATA);
    assign fetch_bus.ack   = sram_bus.ack && (owner == OWN_FETCH);
    assign data_bus.rdata  = (owner == OWN_DATA) ? sram_bus.rdata : '0;
    assign fetch_bus.rdata = (owner == OWN_FETCH) ? sram_bus.rdata : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWN_NONE;
        end else if (sram_bus.ack) begin
            owner <= OWN_NONE;
        end else begin
            owner <= sel;
        end
    end

    // every SRAM reply reaches exactly one requester
    a_one_ack: assert property (@(posedge clk) disable iff (rst)
        sram_bus.ack |-> (fetch_bus.ack ^ data_bus.ack));

endmodule

`default_nettype wire

/* sram_ctrl.sv */
//****************************************
// asynchronous SRAM, one access per request
// pins registered, read sampled at access end
//****************************************
`default_nettype none

module sram_ctrl import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    mem_bus_if.responder    bus,
    output sram_addr_t      sram_addr_o,
    inout  wire word_t      sram_data_io,
    output logic            sram_ce_n_o,
    output logic            sram_oe_n_o,
    output logic            sram_we_n_o,
    output be_t             sram_be_n_o
);
    typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_REPLY} state_t;

    state_t state;
    word_t  wdata_q;
    word_t  rdata_q;
    logic   drive_q;

    assign sram_data_io = drive_q ? wdata_q : 'z;
    assign bus.ack      = (state == ST_REPLY);
    assign bus.rdata    = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            sram_addr_o <= '1;
            sram_be_n_o <= 4'b1111;
            sram_ce_n_o <= 1'b1;
            sram_oe_n_o <= 1'b1;
            sram_we_n_o <= 1'b1;
            drive_q     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (bus.req) begin
                        state       <= ST_ACCESS;
                        sram_addr_o <= bus.addr;
                        sram_be_n_o <= bus.be_n;
                        sram_ce_n_o <= 1'b0;
                        sram_oe_n_o <= bus.we;
                        sram_we_n_o <= !bus.we;
                        drive_q     <= bus.we;
                    end
                end
                ST_ACCESS: begin
                    state       <= ST_REPLY;
                    sram_be_n_o <= 4'b1111;
                    sram_ce_n_o <= 1'b1;
                    sram_oe_n_o <= 1'b1;
                    sram_we_n_o <= 1'b1;
                    drive_q     <= 1'b0;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && bus.req) begin
            wdata_q <= bus.wdata;
        end
        if (state == ST_ACCESS) begin
            rdata_q <= sram_data_io;
        end
    end

    // requester keeps req up until it sees ack
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        state != ST_IDLE |-> bus.req);

endmodule

`default_nettype wire

/* io_regs.sv */
//****************************************
// btn_i assumed synchronous to clk
// pending presses clear when BTN_ADDR is read
//****************************************
`default_nettype none

`include "mem_defs.svh"

module io_regs import mem_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    mem_bus_if.responder        bus,
    input  logic [`BTN_W-1:0]   btn_i,
    output logic                irq_o,
    output logic [15:0]         led_o,
    output logic [3:0]          dpy0_o,
    output logic [3:0]          dpy1_o
);
    localparam sram_addr_t LED_WA = sram_addr_t'(`LED_ADDR >> 2);
    localparam sram_addr_t DPY_WA = sram_addr_t'(`DPY_ADDR >> 2);
    localparam sram_addr_t BTN_WA = sram_addr_t'(`BTN_ADDR >> 2);

    logic [`BTN_W-1:0] pending;
    logic [`BTN_W-1:0] capture;
    logic              btn_held;
    logic              access;
    logic              btn_read;
    word_t             rdata_q;

    assign access   = bus.req && !bus.ack;
    assign btn_read = access && !bus.we && bus.addr == BTN_WA;
    // only a press after full release counts
    assign capture  = btn_held ? '0 : btn_i;
    assign irq_o    = |pending;

    assign bus.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.ack  <= 1'b0;
            led_o    <= '0;
            dpy0_o   <= '0;
            dpy1_o   <= '0;
            pending  <= '0;
            btn_held <= 1'b0;
        end else begin
            bus.ack  <= access;
            btn_held <= |btn_i;
            pending  <= (btn_read ? '0 : pending) | capture;
            if (access && bus.we) begin
                if (bus.addr == LED_WA) begin
                    if (!bus.be_n[0]) led_o[7:0]  <= bus.wdata[7:0];
                    if (!bus.be_n[1]) led_o[15:8] <= bus.wdata[15:8];
                end
                if (bus.addr == DPY_WA && !bus.be_n[0]) begin
                    dpy0_o <= bus.wdata[3:0];
                    dpy1_o <= bus.wdata[7:4];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (bus.addr)
                LED_WA:  rdata_q <= {16'b0, led_o};
                DPY_WA:  rdata_q <= {24'b0, dpy1_o, dpy0_o};
                BTN_WA:  rdata_q <= word_t'(pending);
                default: rdata_q <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* mem_subsystem.sv */
//****************************************
// fetch and load/store share one SRAM
// data side has priority over fetch
//****************************************
`default_nettype none

`include "mem_defs.svh"

module mem_subsystem import mem_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // fetch side
    input  logic                fetch_en_i,
    input  logic                redirect_i,
    input  word_t               redirect_pc_i,
    output logic                inst_valid_o,
    output word_t               inst_pc_o,
    output word_t               inst_o,
    // data side
    input  logic                data_req_i,
    input  mem_op_t             data_op_i,
    input  word_t               data_addr_i,
    input  word_t               data_wdata_i,
    output logic                data_done_o,
    output logic                data_err_o,
    output word_t               data_rdata_o,
    // external SRAM
    output sram_addr_t          sram_addr_o,
    inout  wire word_t          sram_data_io,
    output logic                sram_ce_n_o,
    output logic                sram_oe_n_o,
    output logic                sram_we_n_o,
    output be_t                 sram_be_n_o,
    // board I/O
    input  logic [`BTN_W-1:0]   btn_i,
    output logic                irq_o,
    output logic [15:0]         led_o,
    output logic [3:0]          dpy0_o,
    output logic [3:0]          dpy1_o
);
    mem_bus_if fetch_bus ();
    mem_bus_if data_bus ();
    mem_bus_if sram_bus ();
    mem_bus_if io_bus ();

    fetch_unit i_fetch (
        .clk           (clk),
        .rst           (rst),
        .fetch_en_i    (fetch_en_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .bus           (fetch_bus.requester),
        .inst_valid_o  (inst_valid_o),
        .inst_pc_o     (inst_pc_o),
        .inst_o        (inst_o)
    );

    load_store_unit i_lsu (
        .clk          (clk),
        .rst          (rst),
        .data_req_i   (data_req_i),
        .data_op_i    (data_op_i),
        .data_addr_i  (data_addr_i),
        .data_wdata_i (data_wdata_i),
        .mem_bus      (data_bus.requester),
        .io_bus       (io_bus.requester),
        .data_done_o  (data_done_o),
        .data_err_o   (data_err_o),
        .data_rdata_o (data_rdata_o)
    );

    bus_arbiter i_arb (
        .clk       (clk),
        .rst       (rst),
        .fetch_bus (fetch_bus.responder),
        .data_bus  (data_bus.responder),
        .sram_bus  (sram_bus.requester)
    );

    sram_ctrl i_sram (
        .clk          (clk),
        .rst          (rst),
        .bus          (sram_bus.responder),
        .sram_addr_o  (sram_addr_o),
        .sram_data_io (sram_data_io),
        .sram_ce_n_o  (sram_ce_n_o),
        .sram_oe_n_o  (sram_oe_n_o),
        .sram_we_n_o  (sram_we_n_o),
        .sram_be_n_o  (sram_be_n_o)
    );

    io_regs i_io (
        .clk    (clk),
        .rst    (rst),
        .bus    (io_bus.responder),
        .btn_i  (btn_i),
        .irq_o  (irq_o),
        .led_o  (led_o),
        .dpy0_o (dpy0_o),
        .dpy1_o (dpy1_o)
    );

endmodule

`default_nettype wire

/* sram_model.sv */
//****************************************
// asynchronous SRAM, no timing checks
// write lanes sampled 10 ns into the we_n pulse
//****************************************
`default_nettype none

`include "mem_defs.svh"

module sram_model (
    input  logic [`SRAM_AW-1:0] addr_i,
    inout  wire  [`DATA_W-1:0]  data_io,
    input  logic                ce_n_i,
    input  logic                oe_n_i,
    input  logic                we_n_i,
    input  logic [3:0]          be_n_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // backdoor storage, also written directly by the testbench
    logic [`DATA_W-1:0] mem [0:(1<<`SRAM_AW)-1];
    logic               reading;

    // reads return the whole word, lanes are picked by the requester
    assign reading = !ce_n_i && !oe_n_i && we_n_i;
    assign data_io = reading ? mem[addr_i] : 'z;

    // pins settle well before mid cycle
    always @(negedge we_n_i) begin
        #10;
        if (!ce_n_i && !we_n_i) begin
            for (int i = 0; i < 4; i++) begin
                if (!be_n_i[i]) begin
                    mem[addr_i][8*i +: 8] = data_io[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_mem_subsystem.sv */
//****************************************
// fetch region and data region kept apart
// shadow array mirrors the SRAM model
//****************************************
`default_nettype none

`include "mem_defs.svh"

module tb_mem_subsystem import mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    WAIT_LIMIT = 200;
    localparam int    N_RANDOM   = 200;
    localparam int    MEM_WORDS  = 4096;
    localparam int    DATA_WORDS = 16;
    localparam word_t DATA_BASE  = 32'h0000_3000;

    logic              clk;
    logic              rst;
    logic              fetch_en_i;
    logic              redirect_i;
    word_t             redirect_pc_i;
    logic              inst_valid_o;
    word_t             inst_pc_o;
    word_t             inst_o;
    logic              data_req_i;
    mem_op_t           data_op_i;
    word_t             data_addr_i;
    word_t             data_wdata_i;
    logic              data_done_o;
    logic              data_err_o;
    word_t             data_rdata_o;
    sram_addr_t        sram_addr_o;
    wire word_t        sram_data_io;
    logic              sram_ce_n_o;
    logic              sram_oe_n_o;
    logic              sram_we_n_o;
    be_t               sram_be_n_o;
    logic [`BTN_W-1:0] btn_i;
    logic              irq_o;
    logic [15:0]       led_o;
    logic [3:0]        dpy0_o;
    logic [3:0]        dpy1_o;

    integer seed;
    string  cur_test;
    int     n_tests;
    int     n_chk;
    int     n_err;
    int     n_inst;
    int     chk0;
    int     err0;
    word_t  exp_pc;
    word_t  shadow [0:MEM_WORDS-1];
    word_t  exp_rd_q [$];
    logic   exp_chk_q [$];
    logic   exp_err_q [$];

    mem_subsystem i_dut (.*);

    sram_model i_sram_mem (
        .addr_i  (sram_addr_o),
        .data_io (sram_data_io),
        .ce_n_i  (sram_ce_n_o),
        .oe_n_i  (sram_oe_n_o),
        .we_n_i  (sram_we_n_o),
        .be_n_i  (sram_be_n_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t pattern(input sram_addr_t a);
        return {a[11:0] ^ 12'h9c3, a};
    endfunction

    function automatic int op_size(input mem_op_t op);
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: return 2;
            MEM_LW, MEM_SW:          return 4;
            default:                 return 1;
        endcase
    endfunction

    // expected load result, new memory word and error flag of one operation
    function automatic void predict(input mem_op_t op, input logic [1:0] off,
                                    input word_t wdata, input word_t old,
                                    output word_t rd, output word_t nw, output logic err);
        logic [7:0]  b;
        logic [15:0] h;
        b   = old[8*off +: 8];
        h   = old[16*off[1] +: 16];
        rd  = '0;
        nw  = old;
        err = (op_size(op) == 2 && off[0]) || (op_size(op) == 4 && off != 2'b00);
        if (!err) begin
            case (op)
                MEM_LB:  rd = {{24{b[7]}}, b};
                MEM_LBU: rd = {24'h0, b};
                MEM_LH:  rd = {{16{h[15]}}, h};
                MEM_LHU: rd = {16'h0, h};
                MEM_LW:  rd = old;
                MEM_SB:  nw[8*off +: 8] = wdata[7:0];
                MEM_SH:  nw[16*off[1] +: 16] = wdata[15:0];
                MEM_SW:  nw = wdata;
                default: rd = '0;
            endcase
        end
    endfunction

    task automatic abort_run(input string what);
        $display("timeout in test %s: %s", cur_test, what);
        $display("Errors found");
        $finish;
    endtask

    task automatic check_value(input string what, input word_t exp_v, input word_t act);
        n_chk++;
        assert (act === exp_v) else begin
            $display("ERROR %s: %s expected %h actual %h", cur_test, what, exp_v, act);
            n_err++;
        end
    endtask

    task automatic hold(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic wait_done();
        int cnt;
        cnt = 0;
        do begin
            @(posedge clk);
            #5;
            cnt++;
        end while (!data_done_o && cnt < WAIT_LIMIT);
        if (!data_done_o) abort_run("no data_done_o");
    endtask

    task automatic wait_inst(input int count);
        int cnt;
        int target;
        cnt    = 0;
        target = n_inst + count;
        do begin
            @(posedge clk);
            #5;
            cnt++;
        end while (n_inst < target && cnt < WAIT_LIMIT);
        if (n_inst < target) abort_run("fetch stopped delivering instructions");
    endtask

    task automatic wait_irq();
        int cnt;
        cnt = 0;
        do begin
            @(posedge clk);
            #5;
            cnt++;
        end while (!irq_o && cnt < WAIT_LIMIT);
        if (!irq_o) abort_run("irq_o never rose after a press");
    endtask

    task automatic issue(input mem_op_t op, input word_t addr, input word_t wdata,
                         input word_t exp_rd, input logic chk_rd, input logic exp_err);
        exp_rd_q.push_back(exp_rd);
        exp_chk_q.push_back(chk_rd);
        exp_err_q.push_back(exp_err);
        data_op_i    = op;
        data_addr_i  = addr;
        data_wdata_i = wdata;
        data_req_i   = 1'b1;
        wait_done();
        data_req_i = 1'b0;
    endtask

    task automatic sram_op(input mem_op_t op, input word_t addr, input word_t wdata);
        word_t rd;
        word_t nw;
        logic  err;
        predict(op, addr[1:0], wdata, shadow[addr[13:2]], rd, nw, err);
        issue(op, addr, wdata, rd, op < MEM_SB && !err, err);
        shadow[addr[13:2]] = nw;
    endtask

    task automatic check_backdoor();
        for (int a = DATA_BASE >> 2; a < (DATA_BASE >> 2) + DATA_WORDS; a++) begin
            check_value("model word", shadow[a], i_sram_mem.mem[a]);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        chk0     = n_chk;
        err0     = n_err;
    endtask

    task automatic end_test();
        n_tests++;
        $display("test %-12s %0d checks, %0d errors", cur_test, n_chk - chk0, n_err - err0);
    endtask

    // compares every done and inst_valid pulse
    always @(posedge clk) begin
        word_t e_rd;
        logic  e_chk;
        logic  e_err;
        if (!rst && data_done_o) begin
            if (exp_rd_q.size() == 0) begin
                $display("data_done_o pulsed with no operation pending in test %s", cur_test);
                n_err++;
            end else begin
                e_rd  = exp_rd_q.pop_front();
                e_chk = exp_chk_q.pop_front();
                e_err = exp_err_q.pop_front();
                n_chk++;
                assert (data_err_o === e_err) else begin
                    $display("ERROR %s: err expected %b actual %b", cur_test, e_err, data_err_o);
                    n_err++;
                end
                if (e_chk) begin
                    n_chk++;
                    assert (data_rdata_o === e_rd) else begin
                        $display("ERROR %s: rdata expected %h actual %h",
                                 cur_test, e_rd, data_rdata_o);
                        n_err++;
                    end
                end
            end
        end
        if (!rst && inst_valid_o) begin
            n_inst++;
            n_chk += 2;
            assert (inst_pc_o === exp_pc) else begin
                $display("ERROR %s: inst_pc expected %h actual %h", cur_test, exp_pc, inst_pc_o);
                n_err++;
            end
            assert (inst_o === shadow[exp_pc[13:2]]) else begin
                $display("ERROR %s: inst expected %h actual %h",
                         cur_test, shadow[exp_pc[13:2]], inst_o);
                n_err++;
            end
            exp_pc = exp_pc + 32'd4;
        end
        // a redirect seen at this edge decides the next valid pc
        if (rst) begin
            exp_pc = `RESET_PC;
        end else if (redirect_i) begin
            exp_pc = redirect_pc_i;
        end
    end

    initial begin
        mem_op_t    st;
        mem_op_t    op;
        logic [1:0] off;
        int         r;
        int         inst0;
        seed          = 84462;
        rst           = 1'b1;
        fetch_en_i    = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        data_req_i    = 1'b0;
        data_op_i     = MEM_NONE;
        data_addr_i   = '0;
        data_wdata_i  = '0;
        btn_i         = '0;
        cur_test      = "reset";
        for (int a = 0; a < MEM_WORDS; a++) begin
            shadow[a]            = pattern(a);
            i_sram_mem.mem[a]    = shadow[a];
        end
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;

        start_test("reset");
        check_value("sram pins", 32'h7f,
                    {sram_ce_n_o, sram_oe_n_o, sram_we_n_o, sram_be_n_o});
        check_value("sram addr", 32'h000f_ffff, sram_addr_o);
        check_value("outputs", '0,
                    {data_done_o, data_err_o, inst_valid_o, irq_o, led_o, dpy0_o, dpy1_o});
        end_test();

        start_test("fetch");
        fetch_en_i = 1'b1;
        wait_inst(8);
        end_test();

        // redirect at different points of a fetch
        start_test("redirect");
        for (int k = 0; k < 4; k++) begin
            wait_inst(1);
            hold(k);
            redirect_i    = 1'b1;
            redirect_pc_i = 32'h100 * (k + 1);
            hold(1);
            redirect_i = 1'b0;
            wait_inst(3);
        end
        fetch_en_i = 1'b0;
        end_test();

        start_test("load_store");
        for (int s = MEM_SB; s <= MEM_SW; s++) begin
            st = mem_op_t'(s);
            for (int so = 0; so < 4; so += op_size(st)) begin
                sram_op(st, DATA_BASE + so, $random(seed));
                for (int ld = MEM_LB; ld <= MEM_LW; ld++) begin
                    op = mem_op_t'(ld);
                    for (int lo = 0; lo < 4; lo += op_size(op)) begin
                        sram_op(op, DATA_BASE + lo, '0);
                    end
                end
            end
        end
        check_backdoor();
        end_test();

        start_test("contention");
        redirect_i    = 1'b1;
        redirect_pc_i = `RESET_PC;
        hold(1);
        redirect_i = 1'b0;
        fetch_en_i = 1'b1;
        inst0      = n_inst;
        for (int k = 0; k < N_RANDOM; k++) begin
            r   = $random(seed);
            op  = mem_op_t'(1 + $unsigned(r) % 8);
            off = r[9:8];
            if (op_size(op) == 2) off[0] = 1'b0;
            if (op_size(op) == 4) off = 2'b00;
            sram_op(op, DATA_BASE + {26'b0, r[5:2], off}, $random(seed));
        end
        fetch_en_i = 1'b0;
        n_chk++;
        assert (n_inst > inst0) else begin
            $display("fetch made no progress while data operations ran");
            n_err++;
        end
        check_backdoor();
        end_test();

        start_test("misalign");
        sram_op(MEM_LH, DATA_BASE + 1, '0);
        sram_op(MEM_LHU, DATA_BASE + 7, '0);
        sram_op(MEM_LW, DATA_BASE + 9, '0);
        sram_op(MEM_LW, DATA_BASE + 14, '0);
        sram_op(MEM_SH, DATA_BASE + 3, 32'hdead_beef);
        sram_op(MEM_SW, DATA_BASE + 2, 32'hdead_beef);
        sram_op(MEM_SW, DATA_BASE + 19, 32'hdead_beef);
        check_backdoor();
        end_test();

        start_test("io");
        issue(MEM_SW, `IO_BASE + `LED_ADDR, 32'h1234_a5c3, '0, 1'b0, 1'b0);
        check_value("led", 32'h0000_a5c3, led_o);
        issue(MEM_SB, `IO_BASE + `DPY_ADDR, 32'h0000_007e, '0, 1'b0, 1'b0);
        check_value("dpy", 32'h7e, {dpy1_o, dpy0_o});
        issue(MEM_LW, `IO_BASE + `LED_ADDR, '0, 32'h0000_a5c3, 1'b1, 1'b0);
        issue(MEM_LW, `IO_BASE + 32'hc, '0, '0, 1'b1, 1'b0);
        check_value("irq idle", '0, irq_o);
        btn_i = 4'b0101;
        wait_irq();
        hold(3);
        issue(MEM_LW, `IO_BASE + `BTN_ADDR, '0, 32'h5, 1'b1, 1'b0);
        check_value("irq after read", '0, irq_o);
        // button still held, nothing new to capture
        issue(MEM_LW, `IO_BASE + `BTN_ADDR, '0, '0, 1'b1, 1'b0);
        btn_i = '0;
        hold(2);
        btn_i = 4'b0010;
        wait_irq();
        btn_i = '0;
        issue(MEM_LW, `IO_BASE + `BTN_ADDR, '0, 32'h2, 1'b1, 1'b0);
        check_value("irq after second read", '0, irq_o);
        end_test();

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_chk, n_err);
        if (n_err == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
mem_pkg.sv
mem_bus_if.sv
fetch_unit.sv
load_store_unit.sv
bus_arbiter.sv
sram_ctrl.sv
io_regs.sv
mem_subsystem.sv
sram_model.sv
tb_mem_subsystem.sv
